// ==== source/smc_mac_pkg.sv ====
/*
  shared definitions for the multiple access block
  widths and vector typedefs for bus data, sizes and counts
  transfer size codes of the internal bus
  one-hot state codes of the memory controller FSM
*/

package smc_mac_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  localparam int WORD_W  = 32;  // internal bus data
  localparam int BYTE_W  = 8;   // external bus data, byte wide only
  localparam int XSIZE_W = 2;   // transfer size code
  localparam int COUNT_W = 2;   // up to four accesses
  localparam int STATE_W = 5;   // one bit per controller state

  // ----------------------------------------
  // types
  // ----------------------------------------

  typedef logic [WORD_W-1:0]  word_t;          // internal bus word
  typedef logic [BYTE_W-1:0]  byte_t;          // external bus byte
  typedef logic [XSIZE_W-1:0] xfer_size_t;     // size code
  typedef logic [COUNT_W-1:0] access_count_t;  // remaining accesses minus one
  typedef logic [STATE_W-1:0] smc_state_t;     // one-hot state vector

  // ----------------------------------------
  // transfer size codes
  // ----------------------------------------

  // code 3 is reserved and handled like a byte transfer
  localparam xfer_size_t XSIZ_8  = xfer_size_t'(0);  // byte
  localparam xfer_size_t XSIZ_16 = xfer_size_t'(1);  // halfword
  localparam xfer_size_t XSIZ_32 = xfer_size_t'(2);  // word

  // ----------------------------------------
  // controller state codes
  // ----------------------------------------

  localparam smc_state_t SMC_IDLE  = smc_state_t'(1);   // no access running
  localparam smc_state_t SMC_LE    = smc_state_t'(2);   // latch enable phase
  localparam smc_state_t SMC_RW    = smc_state_t'(4);   // read or write strobe
  localparam smc_state_t SMC_STORE = smc_state_t'(8);   // hold between accesses
  localparam smc_state_t SMC_FLOAT = smc_state_t'(16);  // bus turnaround

endpackage

// ==== source/smc_access_counter.sv ====
/*
  access counter of the multiple access block
  transfer size register loaded on valid_access
  load value decode from the transfer size
  count of remaining byte accesses and the last access flag
  valid transfer size for the rest of the controller
*/

module smc_access_counter
(
  input  logic                      sys_clk7,
  input  logic                      n_sys_reset7,   // active low, async
  input  logic                      valid_access,   // address cycle of new transfer
  input  smc_mac_pkg::xfer_size_t   xfer_size,      // valid with valid_access
  input  logic                      smc_done,       // external access ended
  input  smc_mac_pkg::smc_state_t   smc_nextstate,  // controller next state
  output smc_mac_pkg::xfer_size_t   r_xfer_size,    // stored size
  output smc_mac_pkg::access_count_t r_num_access,  // current count
  output smc_mac_pkg::xfer_size_t   v_xfer_size,    // size valid this cycle
  output logic                      mac_done        // last access
);

  smc_mac_pkg::access_count_t num_accesses;  // load value
  logic                       count_en;      // decrement this edge

  // ----------------------------------------
  // transfer size register
  // ----------------------------------------

  always_ff @(posedge sys_clk7 or negedge n_sys_reset7)
  begin
    if (!n_sys_reset7)
    begin
      r_xfer_size <= smc_mac_pkg::XSIZ_8;
    end
    else if (valid_access)
    begin
      r_xfer_size <= xfer_size;  // held until next transfer
    end
  end

  // current size during address cycle, stored one after it
  assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;

  // ----------------------------------------
  // number of accesses
  // ----------------------------------------

  // byte bus so one access per byte of the transfer
  always_comb
  begin
    case (xfer_size)
      smc_mac_pkg::XSIZ_16: num_accesses = smc_mac_pkg::access_count_t'(1);  // two
      smc_mac_pkg::XSIZ_32: num_accesses = smc_mac_pkg::access_count_t'(3);  // four
      default:              num_accesses = smc_mac_pkg::access_count_t'(0);  // one
    endcase
  end

  // ----------------------------------------
  // access counter
  // ----------------------------------------

  // no step when the controller parks in store or idle
  assign count_en = smc_done &&
                    (smc_nextstate != smc_mac_pkg::SMC_STORE) &&
                    (smc_nextstate != smc_mac_pkg::SMC_IDLE);

  always_ff @(posedge sys_clk7 or negedge n_sys_reset7)
  begin
    if (!n_sys_reset7)
    begin
      r_num_access <= '0;
    end
    else if (valid_access)
    begin
      r_num_access <= num_accesses;  // new transfer wins over done
    end
    else if (count_en)
    begin
      // wraps from zero, controller never asks for that
      r_num_access <= r_num_access - smc_mac_pkg::access_count_t'(1);
    end
  end

  // ----------------------------------------
  // last access flag
  // ----------------------------------------

  assign mac_done = (r_num_access == '0);  // high also while idle

endmodule

// ==== source/smc_byte_datapath.sv ====
/*
  byte datapath of the multiple access block
  read store register filled one byte per access, msb first
  read word to the internal bus with replication of small sizes
  write byte steering from the internal word to the external bus
*/

module smc_byte_datapath
(
  input  logic                       sys_clk7,
  input  logic                       n_sys_reset7,  // active low, async
  input  logic                       latch_data,    // data_smc valid this cycle
  input  smc_mac_pkg::xfer_size_t    r_xfer_size,   // stored transfer size
  input  smc_mac_pkg::access_count_t r_num_access,  // selects byte lane
  input  smc_mac_pkg::byte_t         data_smc,      // external read byte
  input  smc_mac_pkg::word_t         write_data,    // internal write word
  output smc_mac_pkg::word_t         read_data,     // word to internal bus
  output smc_mac_pkg::byte_t         smc_data       // external write byte
);

  smc_mac_pkg::word_t r_read_data;  // read store

  // ----------------------------------------
  // read store register
  // ----------------------------------------

  // count 3 starts a word, so lower bytes are cleared there
  // each later access keeps the bytes above its own lane
  always_ff @(posedge sys_clk7 or negedge n_sys_reset7)
  begin
    if (!n_sys_reset7)
    begin
      r_read_data <= '0;
    end
    else if (latch_data)
    begin
      case (r_num_access)
        2'd3:
        begin
          r_read_data <= {data_smc, 24'h0};  // first byte of word
        end
        2'd2:
        begin
          r_read_data <= {r_read_data[31:24], data_smc, 16'h0};
        end
        2'd1:
        begin
          r_read_data <= {r_read_data[31:16], data_smc, 8'h0};  // halfword starts here
        end
        default:
        begin
          r_read_data <= {r_read_data[31:8], data_smc};  // last byte
        end
      endcase
    end
  end

  // ----------------------------------------
  // read data to internal bus
  // ----------------------------------------

  // on the last latch cycle the incoming byte goes straight through
  // so the word is ready without waiting for the store edge
  always_comb
  begin
    case (r_xfer_size)
      smc_mac_pkg::XSIZ_32:
      begin
        if (latch_data)
        begin
          read_data = {r_read_data[31:8], data_smc};
        end
        else
        begin
          read_data = r_read_data;  // full stored word
        end
      end
      smc_mac_pkg::XSIZ_16:
      begin
        if (latch_data)
        begin
          read_data = {2{r_read_data[15:8], data_smc}};  // both halves
        end
        else
        begin
          read_data = {2{r_read_data[15:0]}};
        end
      end
      default:
      begin
        // byte and reserved code
        if (latch_data)
        begin
          read_data = {4{data_smc}};  // all four lanes
        end
        else
        begin
          read_data = {4{r_read_data[7:0]}};
        end
      end
    endcase
  end

  // ----------------------------------------
  // write byte steering
  // ----------------------------------------

  // count runs down so the top byte goes out first
  always_comb
  begin
    case (r_num_access)
      2'd3:    smc_data = write_data[31:24];
      2'd2:    smc_data = write_data[23:16];
      2'd1:    smc_data = write_data[15:8];
      default: smc_data = write_data[7:0];  // single byte or last
    endcase
  end

endmodule

// ==== source/smc_mac.sv ====
/*
  top level of the multiple access block
  access counter and byte datapath joined with plain ports
*/

module smc_mac
(
  input  logic                       sys_clk7,
  input  logic                       n_sys_reset7,   // active low, async
  // from controller and internal bus
  input  logic                       valid_access,   // address cycle strobe
  input  smc_mac_pkg::xfer_size_t    xfer_size,      // valid with valid_access
  input  logic                       smc_done,       // external access ended
  input  smc_mac_pkg::smc_state_t    smc_nextstate,  // one-hot next state
  input  logic                       latch_data,     // read byte valid
  input  smc_mac_pkg::byte_t         data_smc,       // external read byte
  input  smc_mac_pkg::word_t         write_data,     // internal write word
  // to controller and internal bus
  output smc_mac_pkg::access_count_t r_num_access,   // current count
  output logic                       mac_done,       // last access
  output smc_mac_pkg::xfer_size_t    v_xfer_size,    // valid size
  output smc_mac_pkg::word_t         read_data,      // word to internal bus
  output smc_mac_pkg::byte_t         smc_data        // external write byte
);

  smc_mac_pkg::xfer_size_t r_xfer_size;  // stored size for the datapath

  // ----------------------------------------
  // access counter
  // ----------------------------------------

  smc_access_counter u_access_counter
  (
    .sys_clk7      (sys_clk7),
    .n_sys_reset7  (n_sys_reset7),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .r_xfer_size   (r_xfer_size),
    .r_num_access  (r_num_access),  // also feeds the datapath
    .v_xfer_size   (v_xfer_size),
    .mac_done      (mac_done)
  );

  // ----------------------------------------
  // byte datapath
  // ----------------------------------------

  smc_byte_datapath u_byte_datapath
  (
    .sys_clk7     (sys_clk7),
    .n_sys_reset7 (n_sys_reset7),
    .latch_data   (latch_data),
    .r_xfer_size  (r_xfer_size),
    .r_num_access (r_num_access),
    .data_smc     (data_smc),
    .write_data   (write_data),
    .read_data    (read_data),
    .smc_data     (smc_data)
  );

endmodule

// ==== test/smc_mac_properties.sv ====
/*
  concurrent assertions for the multiple access block
  counter load, last access flag, hold in store state
  bound to the top level
*/

module smc_mac_properties
(
  input logic                       sys_clk7,
  input logic                       n_sys_reset7,
  input logic                       valid_access,
  input smc_mac_pkg::xfer_size_t    xfer_size,
  input logic                       smc_done,
  input smc_mac_pkg::smc_state_t    smc_nextstate,
  input smc_mac_pkg::access_count_t r_num_access,
  input logic                       mac_done
);

  timeunit 1ns;
  timeprecision 100ps;

  // one, two or four byte accesses
  function automatic smc_mac_pkg::access_count_t load_of(input smc_mac_pkg::xfer_size_t size);
    if (size == smc_mac_pkg::XSIZ_32)
      return 2'd3;
    else if (size == smc_mac_pkg::XSIZ_16)
      return 2'd1;
    return 2'd0;  // byte and reserved
  endfunction

  // ----------------------------------------
  // counter
  // ----------------------------------------

  load_on_valid: assert property (@(posedge sys_clk7) disable iff (!n_sys_reset7)
    valid_access |=> r_num_access == load_of($past(xfer_size)))
  else $error("count after valid_access does not match the transfer size");

  hold_in_store: assert property (@(posedge sys_clk7) disable iff (!n_sys_reset7)
    (smc_done && !valid_access && smc_nextstate == smc_mac_pkg::SMC_STORE)
      |=> $stable(r_num_access))
  else $error("count changed on smc_done in store state");

  // ----------------------------------------
  // last access flag
  // ----------------------------------------

  // flag after a load is set only for single access transfers
  flag_after_load: assert property (@(posedge sys_clk7) disable iff (!n_sys_reset7)
    valid_access |=> mac_done == (load_of($past(xfer_size)) == 2'd0))
  else $error("mac_done after valid_access does not match the transfer size");

endmodule

bind smc_mac smc_mac_properties u_properties (.*);

// ==== test/smc_mac_tb.sv ====
/*
  testbench for the multiple access block
  clock, reset and lcg driven read and write transfers
  reference functions for read word, write byte and load value
  comparing process at mid cycle, closing report
*/

module smc_mac_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic                       sys_clk7;
  logic                       n_sys_reset7;
  logic                       valid_access;
  smc_mac_pkg::xfer_size_t    xfer_size;
  logic                       smc_done;
  smc_mac_pkg::smc_state_t    smc_nextstate;
  logic                       latch_data;
  smc_mac_pkg::byte_t         data_smc;
  smc_mac_pkg::word_t         write_data;
  smc_mac_pkg::access_count_t r_num_access;
  logic                       mac_done;
  smc_mac_pkg::xfer_size_t    v_xfer_size;
  smc_mac_pkg::word_t         read_data;
  smc_mac_pkg::byte_t         smc_data;

  // model of the registered state advanced at each edge
  smc_mac_pkg::access_count_t model_count;
  smc_mac_pkg::xfer_size_t    model_size;
  smc_mac_pkg::word_t         exp_read;
  smc_mac_pkg::byte_t         exp_write;
  logic                       check_read;   // compare read_data this cycle
  logic                       check_write;  // compare smc_data this cycle
  logic [31:0]                rng_state;
  int                         errors;
  int                         checks;
  int                         loop_i;
  logic                       timed_out;

  smc_mac uut (.*);

  always #50 sys_clk7 = ~sys_clk7;  // 100 ns period

  // ----------------------------------------
  // reference functions
  // ----------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // accesses minus one per transfer size
  // reserved code counts as a byte
  function automatic smc_mac_pkg::access_count_t load_value(input smc_mac_pkg::xfer_size_t size);
    if (size == smc_mac_pkg::XSIZ_32)
      return 2'd3;
    else if (size == smc_mac_pkg::XSIZ_16)
      return 2'd1;
    return 2'd0;
  endfunction

  // sent holds bytes in arrival order with the newest in the low lane
  function automatic smc_mac_pkg::word_t expected_read_word(input smc_mac_pkg::xfer_size_t size,
                                                           input smc_mac_pkg::word_t sent);
    if (size == smc_mac_pkg::XSIZ_32)
      return sent;                  // first byte ends up msb
    else if (size == smc_mac_pkg::XSIZ_16)
      return {2{sent[15:0]}};
    return {4{sent[7:0]}};          // byte lanes replicated
  endfunction

  function automatic smc_mac_pkg::byte_t expected_write_byte(input smc_mac_pkg::word_t data,
                                                            input smc_mac_pkg::access_count_t lane);
    return data[8 * int'(lane) +: 8];
  endfunction

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------

  task automatic draw_random();
    rng_state = lcg_next(rng_state);
  endtask

  // model follows the inputs seen at the edge before the drive delay
  task automatic next_cycle();
    @(posedge sys_clk7);
    if (n_sys_reset7)
    begin
      if (valid_access)
      begin
        model_count = load_value(xfer_size);
        model_size  = xfer_size;
      end
      else if (smc_done && smc_nextstate != smc_mac_pkg::SMC_STORE &&
               smc_nextstate != smc_mac_pkg::SMC_IDLE)
      begin
        model_count = model_count - 2'd1;
      end
    end
    #5;
  endtask

  task automatic run_transfer(input smc_mac_pkg::xfer_size_t size, input logic is_read);
    int                 n;
    int                 idx;
    smc_mac_pkg::word_t sent;
    logic               last;
    n    = int'(load_value(size)) + 1;
    idx  = 0;
    sent = '0;
    last = 1'b0;
    // address cycle
    next_cycle();
    draw_random();
    valid_access  = 1'b1;
    xfer_size     = size;
    write_data    = rng_state;
    smc_done      = 1'b0;
    latch_data    = 1'b0;
    smc_nextstate = smc_mac_pkg::SMC_LE;
    check_read    = 1'b0;
    check_write   = 1'b0;
    // done while parked in store leaves the count
    next_cycle();
    draw_random();
    valid_access  = 1'b0;
    xfer_size     = rng_state[1:0];  // v_xfer_size must ignore this
    smc_done      = 1'b1;
    smc_nextstate = smc_mac_pkg::SMC_STORE;
    check_write   = !is_read;
    exp_write     = expected_write_byte(write_data, smc_mac_pkg::access_count_t'(n - 1));
    while (!last)
    begin
      if (idx == 8)
      begin
        errors++;
        timed_out = 1'b1;
        $display("timeout: mac_done did not rise within %0d accesses", idx);
        break;
      end
      // strobe phase
      next_cycle();
      smc_done      = 1'b0;
      latch_data    = 1'b0;
      smc_nextstate = smc_mac_pkg::SMC_RW;
      exp_write     = expected_write_byte(write_data, smc_mac_pkg::access_count_t'(n - 1 - idx));
      last          = mac_done;  // registered count is stable here
      // access ends
      next_cycle();
      draw_random();
      data_smc      = rng_state[31:24];
      smc_done      = 1'b1;
      latch_data    = is_read;
      smc_nextstate = last ? smc_mac_pkg::SMC_IDLE : smc_mac_pkg::SMC_RW;
      if (is_read)
        sent = {sent[23:0], data_smc};
      if (is_read && last)
      begin
        check_read = 1'b1;
        exp_read   = expected_read_word(size, sent);
      end
      idx++;
    end
    // stored word visible after the last latch
    next_cycle();
    smc_done      = 1'b0;
    latch_data    = 1'b0;
    smc_nextstate = smc_mac_pkg::SMC_FLOAT;  // bus turnaround
    check_write   = 1'b0;
    // done while idle keeps the count at zero
    next_cycle();
    check_read    = 1'b0;
    smc_done      = 1'b1;
    smc_nextstate = smc_mac_pkg::SMC_IDLE;
    next_cycle();
    smc_done = 1'b0;
  endtask

  // ----------------------------------------
  // comparing process at mid cycle
  // ----------------------------------------

  always @(negedge sys_clk7)
  begin
    if (n_sys_reset7)
    begin
      checks++;
      assert (r_num_access === model_count)
      else
      begin
        errors++;
        $display("Fail r_num_access: got %h expected %h", r_num_access, model_count);
      end
      assert (mac_done === (model_count == 2'd0))
      else
      begin
        errors++;
        $display("Fail mac_done: got %h expected %h", mac_done, model_count == 2'd0);
      end
      assert (v_xfer_size === (valid_access ? xfer_size : model_size))
      else
      begin
        errors++;
        $display("Fail v_xfer_size: got %h expected %h", v_xfer_size,
                 valid_access ? xfer_size : model_size);
      end
      if (check_read)
      begin
        assert (read_data === exp_read)
        else
        begin
          errors++;
          $display("Fail read_data: got %h expected %h", read_data, exp_read);
        end
      end
      if (check_write)
      begin
        assert (smc_data === exp_write)
        else
        begin
          errors++;
          $display("Fail smc_data: got %h expected %h", smc_data, exp_write);
        end
      end
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial
  begin
    sys_clk7      = 1'b0;
    n_sys_reset7  = 1'b0;
    valid_access  = 1'b0;
    xfer_size     = smc_mac_pkg::XSIZ_8;
    smc_done      = 1'b0;
    smc_nextstate = smc_mac_pkg::SMC_IDLE;
    latch_data    = 1'b0;
    data_smc      = '0;
    write_data    = '0;
    model_count   = '0;
    model_size    = smc_mac_pkg::XSIZ_8;
    exp_read      = '0;
    exp_write     = '0;
    check_read    = 1'b1;  // read_data is zero out of reset
    check_write   = 1'b0;
    rng_state     = 32'hc78941ef;
    errors        = 0;
    checks        = 0;
    timed_out     = 1'b0;
    repeat (8) @(posedge sys_clk7);
    #5;
    n_sys_reset7 = 1'b1;
    // every size code once as read and as write
    for (loop_i = 0; loop_i < 4 && !timed_out; loop_i++)
    begin
      run_transfer(smc_mac_pkg::xfer_size_t'(loop_i), 1'b1);
      run_transfer(smc_mac_pkg::xfer_size_t'(loop_i), 1'b0);
    end
    for (loop_i = 0; loop_i < 24 && !timed_out; loop_i++)
    begin
      draw_random();
      run_transfer(rng_state[9:8], rng_state[4]);
    end
    next_cycle();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
source/smc_mac_pkg.sv
source/smc_access_counter.sv
source/smc_byte_datapath.sv
source/smc_mac.sv
test/smc_mac_properties.sv
test/smc_mac_tb.sv

// ==== Bender.yml ====
package:
  name: smc_mac

sources:
  - files:
      - source/smc_mac_pkg.sv
      - source/smc_access_counter.sv
      - source/smc_byte_datapath.sv
      - source/smc_mac.sv
  - target: test
    files:
      - test/smc_mac_properties.sv
      - test/smc_mac_tb.sv
